// ==== verilog/mem_pkg.sv ====
package mem_pkg;

	localparam int DATA_W     = 32;
	localparam int ADDR_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int SEL_W      = DATA_W / 8; // one lane per byte

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_LB  = 4'd1,
		OP_LH  = 4'd2,
		OP_LW  = 4'd3,
		OP_LBU = 4'd4,
		OP_LHU = 4'd5,
		OP_SB  = 4'd6,
		OP_SH  = 4'd7,
		OP_SW  = 4'd8
	} mem_op_e;

	typedef enum logic {
		ST_IDLE,
		ST_WAIT
	} ctrl_state_e;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] waddr;
		logic                  we;
		logic [DATA_W-1:0]     wdata;
	} wb_pass_t;

	typedef struct packed {
		mem_op_e               op;
		logic [1:0]            offset;
		logic [REG_ADDR_W-1:0] waddr;
		logic                  we;
	} load_pend_t;

	function automatic logic op_is_load(mem_op_e op);
		return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	endfunction

	function automatic logic op_is_store(mem_op_e op);
		return op inside {OP_SB, OP_SH, OP_SW};
	endfunction

	// half needs even offset, word needs zero
	function automatic logic op_aligned(mem_op_e op, logic [1:0] off);
		case (op)
			OP_LH, OP_LHU, OP_SH : return !off[0];
			OP_LW, OP_SW         : return off == 2'b00;
			default              : return 1'b1;
		endcase
	endfunction

endpackage

// ==== verilog/dmem_if.sv ====
interface dmem_if import mem_pkg::*; ();

	logic [ADDR_W-1:0] addr;
	logic              re;
	logic              we;
	logic [DATA_W-1:0] wdata;
	logic [SEL_W-1:0]  sel;
	logic [DATA_W-1:0] rdata; // valid with done
	logic              busy;
	logic              done;

	modport master (
		output addr, re, we, wdata, sel,
		input  rdata, busy, done
	);

	modport slave (
		input  addr, re, we, wdata, sel,
		output rdata, busy, done
	);

	modport resp (
		input rdata, done
	);

endinterface

// ==== verilog/mem_access_ctrl.sv ====
module mem_access_ctrl import mem_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  op_valid_i,
	input  mem_op_e               op_i,
	input  logic [ADDR_W-1:0]     addr_i,
	input  logic [DATA_W-1:0]     store_data_i,
	input  logic [REG_ADDR_W-1:0] reg_waddr_i,
	input  logic                  reg_we_i,
	input  logic [DATA_W-1:0]     reg_wdata_i,
	dmem_if.master                mem,
	output wb_pass_t              pass_o,
	output load_pend_t            pend_o,
	output logic                  stall_o
);

	ctrl_state_e       state_q;
	logic              accept;
	logic              is_load;
	logic              is_store;
	logic [DATA_W-1:0] st_wdata;
	logic [SEL_W-1:0]  st_sel;
	logic              re_q;
	logic              we_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [SEL_W-1:0]  sel_q;
	load_pend_t        pend_q;

	assign is_load  = op_is_load(op_i);
	assign is_store = op_is_store(op_i);
	assign accept   = op_valid_i && (state_q == ST_IDLE); // strobes during stall dropped
	assign stall_o  = (state_q == ST_WAIT);

	// store lanes from low address bits
	always_comb begin
		case (op_i)
			OP_SB : begin
				st_wdata = {SEL_W{store_data_i[7:0]}};
				st_sel   = SEL_W'(1) << addr_i[1:0];
			end
			OP_SH : begin
				st_wdata = {(SEL_W/2){store_data_i[15:0]}};
				st_sel   = addr_i[1] ? 4'b1100 : 4'b0011;
			end
			OP_SW : begin
				st_wdata = store_data_i;
				st_sel   = '1;
			end
			default : begin
				st_wdata = store_data_i;
				st_sel   = '0;
			end
		endcase
		if (!op_aligned(op_i, addr_i[1:0]))
			st_sel = '0; // misaligned store writes nothing
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE : if (accept && (is_load || is_store)) state_q <= ST_WAIT;
				ST_WAIT : if (mem.done) state_q <= ST_IDLE;
				default : state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			re_q <= 1'b0;
			we_q <= 1'b0;
		end else begin
			re_q <= accept && is_load; // single cycle pulses
			we_q <= accept && is_store;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && is_load) begin
			addr_q <= {addr_i[ADDR_W-1:2], 2'b00};
			sel_q  <= '0;
			pend_q <= '{op: op_i, offset: addr_i[1:0], waddr: reg_waddr_i, we: reg_we_i};
		end else if (accept && is_store) begin
			addr_q  <= addr_i;
			wdata_q <= st_wdata;
			sel_q   <= st_sel;
			pend_q  <= '{op: op_i, offset: addr_i[1:0], waddr: reg_waddr_i, we: reg_we_i};
		end
	end

	assign mem.addr  = addr_q;
	assign mem.re    = re_q;
	assign mem.we    = we_q;
	assign mem.wdata = wdata_q;
	assign mem.sel   = sel_q;

	assign pend_o = pend_q;

	// immediate writeback for non-load ops
	always_comb begin
		pass_o.valid = accept && !is_load;
		pass_o.waddr = reg_waddr_i;
		pass_o.we    = reg_we_i;
		pass_o.wdata = is_store ? '0 : reg_wdata_i;
	end

endmodule

// ==== verilog/data_ram.sv ====
module data_ram import mem_pkg::*; #(
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 3
) (
	input  logic clk,
	input  logic rst,
	dmem_if.slave mem
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	logic [DATA_W-1:0] mem_q [MEM_WORDS];
	logic [ADDR_W-3:0] word_addr;
	logic [IDX_W-1:0]  idx;
	logic [DATA_W-1:0] rdata_q;
	logic [CNT_W-1:0]  cnt_q;

	assign word_addr = mem.addr[ADDR_W-1:2];
	assign idx       = IDX_W'(word_addr % MEM_WORDS); // wraps past depth

	// byte lane writes land in the request cycle
	always_ff @(posedge clk) begin
		for (int i = 0; i < SEL_W; i++) begin
			if (mem.we && mem.sel[i])
				mem_q[idx][8*i +: 8] <= mem.wdata[8*i +: 8];
		end
	end

	// contents at request time
	always_ff @(posedge clk) begin
		if (mem.re)
			rdata_q <= mem_q[idx];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q <= '0;
		end else if (mem.re || mem.we) begin
			cnt_q <= CNT_W'(MEM_LATENCY);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign mem.busy  = (cnt_q != '0);
	assign mem.done  = (cnt_q == CNT_W'(1)); // last busy cycle
	assign mem.rdata = rdata_q;

endmodule

// ==== verilog/load_align.sv ====
module load_align import mem_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	dmem_if.resp                   mem,
	input  wb_pass_t               pass_i,
	input  load_pend_t             pend_i,
	output logic                   wb_valid_o,
	output logic                   wb_we_o,
	output logic [REG_ADDR_W-1:0]  wb_waddr_o,
	output logic [DATA_W-1:0]      wb_wdata_o
);

	logic              load_done;
	logic [DATA_W-1:0] shifted;
	logic [7:0]        lb;
	logic [15:0]       lh;
	logic [DATA_W-1:0] ld_data;

	assign load_done = mem.done && op_is_load(pend_i.op);
	assign shifted   = mem.rdata >> (8 * pend_i.offset); // wanted lane to bottom
	assign lb        = shifted[7:0];
	assign lh        = shifted[15:0];

	always_comb begin
		case (pend_i.op)
			OP_LB   : ld_data = {{(DATA_W-8){lb[7]}}, lb};
			OP_LBU  : ld_data = {{(DATA_W-8){1'b0}}, lb};
			OP_LH   : ld_data = {{(DATA_W-16){lh[15]}}, lh};
			OP_LHU  : ld_data = {{(DATA_W-16){1'b0}}, lh};
			OP_LW   : ld_data = mem.rdata;
			default : ld_data = '0;
		endcase
		if (!op_aligned(pend_i.op, pend_i.offset))
			ld_data = '0; // misaligned load reads zero
	end

	always_ff @(posedge clk) begin
		if (rst)
			wb_valid_o <= 1'b0;
		else
			wb_valid_o <= load_done || pass_i.valid;
	end

	always_ff @(posedge clk) begin
		if (load_done) begin
			wb_we_o    <= pend_i.we;
			wb_waddr_o <= pend_i.waddr;
			wb_wdata_o <= ld_data;
		end else begin
			wb_we_o    <= pass_i.we;
			wb_waddr_o <= pass_i.waddr;
			wb_wdata_o <= pass_i.wdata;
		end
	end

endmodule

// ==== verilog/mem_subsys.sv ====
module mem_subsys import mem_pkg::*; #(
	parameter int MEM_WORDS   = 256,
	parameter int MEM_LATENCY = 3
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  op_valid_i,
	input  mem_op_e               op_i,
	input  logic [ADDR_W-1:0]     addr_i,
	input  logic [DATA_W-1:0]     store_data_i,
	input  logic [REG_ADDR_W-1:0] reg_waddr_i,
	input  logic                  reg_we_i,
	input  logic [DATA_W-1:0]     reg_wdata_i,
	output logic                  wb_valid_o,
	output logic                  wb_we_o,
	output logic [REG_ADDR_W-1:0] wb_waddr_o,
	output logic [DATA_W-1:0]     wb_wdata_o,
	output logic                  stall_o
);

	wb_pass_t   pass;
	load_pend_t pend;

	dmem_if u_dmem ();

	mem_access_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.op_valid_i   (op_valid_i),
		.op_i         (op_i),
		.addr_i       (addr_i),
		.store_data_i (store_data_i),
		.reg_waddr_i  (reg_waddr_i),
		.reg_we_i     (reg_we_i),
		.reg_wdata_i  (reg_wdata_i),
		.mem          (u_dmem.master),
		.pass_o       (pass),
		.pend_o       (pend),
		.stall_o      (stall_o)
	);

	data_ram #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) u_ram (
		.clk (clk),
		.rst (rst),
		.mem (u_dmem.slave)
	);

	load_align u_align (
		.clk        (clk),
		.rst        (rst),
		.mem        (u_dmem.resp),
		.pass_i     (pass),
		.pend_i     (pend),
		.wb_valid_o (wb_valid_o),
		.wb_we_o    (wb_we_o),
		.wb_waddr_o (wb_waddr_o),
		.wb_wdata_o (wb_wdata_o)
	);

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 4
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

endmodule

// ==== test/tb_mem_subsys.sv ====
module tb_mem_subsys import mem_pkg::*; ();

	localparam int MEM_WORDS   = 256;
	localparam int MEM_LATENCY = 3;
	localparam int NUM_TESTS   = 6;
	localparam int WAIT_LIMIT  = MEM_LATENCY + 8;

	logic                  clk;
	logic                  rst;
	logic                  op_valid;
	mem_op_e               op;
	logic [ADDR_W-1:0]     addr;
	logic [DATA_W-1:0]     store_data;
	logic [REG_ADDR_W-1:0] reg_waddr;
	logic                  reg_we;
	logic [DATA_W-1:0]     reg_wdata;
	logic                  wb_valid;
	logic                  wb_we;
	logic [REG_ADDR_W-1:0] wb_waddr;
	logic [DATA_W-1:0]     wb_wdata;
	logic                  stall;

	int                seed       = 28435;
	int                err_count  = 0;
	int                pass_count = 0;
	int                fail_count = 0;
	logic [DATA_W-1:0] ref_mem [MEM_WORDS]; // expected RAM contents
	logic [DATA_W-1:0] last_wb_data;

	tb_clock u_clk (.clk_o(clk));

	mem_subsys #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem_subsys (
		.clk          (clk),
		.rst          (rst),
		.op_valid_i   (op_valid),
		.op_i         (op),
		.addr_i       (addr),
		.store_data_i (store_data),
		.reg_waddr_i  (reg_waddr),
		.reg_we_i     (reg_we),
		.reg_wdata_i  (reg_wdata),
		.wb_valid_o   (wb_valid),
		.wb_we_o      (wb_we),
		.wb_waddr_o   (wb_waddr),
		.wb_wdata_o   (wb_wdata),
		.stall_o      (stall)
	);

	task automatic check(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act,
			input string msg);
		if (act !== exp) begin
			err_count++;
			$display("Mismatch at %0t: %s, expected %h, got %h", $time, msg, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: failed with %0d errors", name, err_count - errs_before);
		end
	endtask

	function automatic logic [ADDR_W-1:0] rand_addr();
		return {$random(seed)} & 32'hffff_fffc;
	endfunction

	function automatic int word_index(input logic [ADDR_W-1:0] a);
		return int'(a[ADDR_W-1:2] % MEM_WORDS); // RAM wraps past its depth
	endfunction

	function automatic void store_ref(input mem_op_e code, input logic [ADDR_W-1:0] a,
			input logic [DATA_W-1:0] d);
		int         idx;
		logic [1:0] off;
		idx = word_index(a);
		off = a[1:0];
		case (code)
			OP_SB : ref_mem[idx][8*off +: 8] = d[7:0];
			OP_SH : begin
				if (off == 2'd0)
					ref_mem[idx][15:0] = d[15:0];
				else if (off == 2'd2)
					ref_mem[idx][31:16] = d[15:0];
			end
			OP_SW : if (off == 2'd0) ref_mem[idx] = d;
			default : ;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] load_ref(input mem_op_e code,
			input logic [ADDR_W-1:0] a);
		logic [DATA_W-1:0] w;
		logic [1:0]        off;
		logic [7:0]        b;
		logic [15:0]       h;
		w   = ref_mem[word_index(a)];
		off = a[1:0];
		b   = w[8*off +: 8];
		h   = off[1] ? w[31:16] : w[15:0];
		case (code)
			OP_LB   : return {{24{b[7]}}, b};
			OP_LBU  : return {24'h0, b};
			OP_LH   : return off[0] ? '0 : {{16{h[15]}}, h};
			OP_LHU  : return off[0] ? '0 : {16'h0, h};
			OP_LW   : return (off == 2'd0) ? w : '0;
			default : return '0;
		endcase
	endfunction

	// one strobe, then follow stall and writeback until the access is over
	task automatic run_op(input mem_op_e code, input logic [ADDR_W-1:0] a,
			input logic [DATA_W-1:0] sdata);
		logic [REG_ADDR_W-1:0] waddr;
		logic                  we;
		logic [DATA_W-1:0]     rwdata;
		logic [DATA_W-1:0]     exp_data;
		logic [DATA_W-1:0]     got_data;
		logic [REG_ADDR_W-1:0] got_waddr;
		logic                  got_we;
		logic                  is_ld;
		logic                  is_st;
		int                    exp_lat;
		int                    lat;
		int                    n;
		int                    wb_seen;
		waddr    = $random(seed);
		we       = $random(seed);
		rwdata   = $random(seed);
		is_ld    = code inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
		is_st    = code inside {OP_SB, OP_SH, OP_SW};
		exp_lat  = is_ld ? MEM_LATENCY + 2 : 1;
		exp_data = is_ld ? load_ref(code, a) : (is_st ? '0 : rwdata);
		got_data = '0;
		lat      = 0;
		n        = 0;
		wb_seen  = 0;
		@(posedge clk);
		op_valid   <= 1'b1;
		op         <= code;
		addr       <= a;
		store_data <= sdata;
		reg_waddr  <= waddr;
		reg_we     <= we;
		reg_wdata  <= rwdata;
		@(posedge clk);
		op_valid <= 1'b0;
		do begin
			@(negedge clk);
			n++;
			check((is_ld || is_st) && n <= MEM_LATENCY + 1, stall,
				$sformatf("%s stall in cycle %0d", code.name(), n));
			if (wb_valid) begin
				if (wb_seen == 0) begin
					lat       = n;
					got_data  = wb_wdata;
					got_waddr = wb_waddr;
					got_we    = wb_we;
				end
				wb_seen++;
			end
		end while (n < WAIT_LIMIT && !(wb_seen != 0 && !stall && !wb_valid));
		if (wb_seen == 0 || stall) begin
			err_count++;
			$display("%s at %h: no writeback or stall still high after %0d cycles",
				code.name(), a, WAIT_LIMIT);
		end else begin
			check(exp_lat, lat, $sformatf("%s writeback latency", code.name()));
			check(1, wb_seen, $sformatf("%s writeback count", code.name()));
			check(exp_data, got_data, $sformatf("%s data at %h", code.name(), a));
			check(waddr, got_waddr, $sformatf("%s register index", code.name()));
			check(we, got_we, $sformatf("%s write enable", code.name()));
		end
		last_wb_data = got_data;
		if (is_st)
			store_ref(code, a, sdata);
	endtask

	task automatic reset_and_passthru();
		int errs;
		errs = err_count;
		@(negedge clk);
		check(0, wb_valid, "wb_valid after reset");
		check(0, stall, "stall after reset");
		repeat (4) run_op(OP_NOP, rand_addr(), $random(seed));
		report_test("reset and pass-through", errs);
	endtask

	task automatic word_store_load();
		int                errs;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		errs = err_count;
		repeat (8) begin
			a = rand_addr();
			d = $random(seed);
			run_op(OP_SW, a, d);
			run_op(OP_LW, a, '0);
			check(d, last_wb_data, "word read back");
		end
		report_test("word store and load", errs);
	endtask

	task automatic partial_stores();
		int                errs;
		int                off;
		logic [ADDR_W-1:0] base;
		errs = err_count;
		for (off = 0; off < 4; off++) begin
			base = rand_addr();
			run_op(OP_SW, base, $random(seed));
			run_op(OP_SB, base + off, $random(seed));
			run_op(OP_LW, base, '0);
		end
		for (off = 0; off < 4; off += 2) begin
			base = rand_addr();
			run_op(OP_SW, base, $random(seed));
			run_op(OP_SH, base + off, $random(seed));
			run_op(OP_LW, base, '0);
		end
		report_test("byte and halfword stores", errs);
	endtask

	task automatic load_extension();
		int                errs;
		int                p;
		int                off;
		logic [ADDR_W-1:0] base;
		logic [DATA_W-1:0] pat;
		errs = err_count;
		for (p = 0; p < 2; p++) begin
			base    = rand_addr();
			pat     = $random(seed);
			pat[7]  = !p[0]; // top bits set and clear across lanes
			pat[15] = p[0];
			pat[23] = p[0];
			pat[31] = !p[0];
			run_op(OP_SW, base, pat);
			for (off = 0; off < 4; off++) begin
				run_op(OP_LB, base + off, '0);
				run_op(OP_LBU, base + off, '0);
			end
			for (off = 0; off < 4; off += 2) begin
				run_op(OP_LH, base + off, '0);
				run_op(OP_LHU, base + off, '0);
			end
		end
		report_test("load sign and zero extension", errs);
	endtask

	task automatic misaligned_access();
		int                errs;
		int                off;
		logic [ADDR_W-1:0] base;
		logic [DATA_W-1:0] pat;
		errs = err_count;
		base = rand_addr();
		pat  = $random(seed);
		run_op(OP_SW, base, pat);
		run_op(OP_SH, base + 1, ~pat);
		run_op(OP_SH, base + 3, ~pat);
		for (off = 1; off < 4; off++)
			run_op(OP_SW, base + off, ~pat);
		run_op(OP_LW, base, '0);
		check(pat, last_wb_data, "word after misaligned stores");
		for (off = 1; off < 4; off += 2) begin
			run_op(OP_LH, base + off, '0);
			check(0, last_wb_data, "misaligned LH");
			run_op(OP_LHU, base + off, '0);
			check(0, last_wb_data, "misaligned LHU");
		end
		for (off = 1; off < 4; off++) begin
			run_op(OP_LW, base + off, '0);
			check(0, last_wb_data, "misaligned LW");
		end
		report_test("misaligned accesses", errs);
	endtask

	task automatic strobe_during_stall();
		int                errs;
		int                n;
		int                wb_seen;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		errs = err_count;
		a    = rand_addr();
		d    = $random(seed);
		@(posedge clk);
		op_valid   <= 1'b1;
		op         <= OP_SW;
		addr       <= a;
		store_data <= d;
		@(posedge clk);
		op_valid <= 1'b0;
		@(negedge clk);
		wb_seen = wb_valid;
		check(1, stall, "stall after store strobe");
		@(posedge clk);
		op_valid   <= 1'b1; // lands while the store is outstanding
		store_data <= ~d;
		@(posedge clk);
		op_valid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (wb_valid)
				wb_seen++;
		end while (stall && n < WAIT_LIMIT);
		if (stall) begin
			err_count++;
			$display("stall stayed high after a store with a strobe during the stall");
		end
		check(1, wb_seen, "writebacks with a strobe during the stall");
		store_ref(OP_SW, a, d);
		run_op(OP_LW, a, '0);
		report_test("strobe during stall", errs);
	endtask

	initial begin
		repeat (NUM_TESTS * 64 * (MEM_LATENCY + 4)) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst        <= 1'b1;
		op_valid   <= 1'b0;
		op         <= OP_NOP;
		addr       <= '0;
		store_data <= '0;
		reg_waddr  <= '0;
		reg_we     <= 1'b0;
		reg_wdata  <= '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		reset_and_passthru();
		word_store_load();
		partial_stores();
		load_extension();
		misaligned_access();
		strobe_during_stall();
		$display("tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== mem_subsys.f ====
verilog/mem_pkg.sv
verilog/dmem_if.sv
verilog/mem_access_ctrl.sv
verilog/data_ram.sv
verilog/load_align.sv
verilog/mem_subsys.sv
test/tb_clock.sv
test/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - verilog/mem_pkg.sv
  - verilog/dmem_if.sv
  - verilog/mem_access_ctrl.sv
  - verilog/data_ram.sv
  - verilog/load_align.sv
  - verilog/mem_subsys.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_mem_subsys.sv
